// File: Bender.yml
package:
  name: pcr_accuracy_adapt

sources:
  - logic/pcr_pkg.sv
  - logic/pcr_field_parser.sv
  - logic/pcr_history_ram.sv
  - logic/pcr_correct_pipe.sv
  - logic/pcr_accuracy_adapt.sv
  - target: test
    files:
      - testbench/tb_pcr_accuracy_adapt.sv

// File: logic/pcr_accuracy_adapt.sv
`timescale 1ns/1ps

module pcr_accuracy_adapt #(
    parameter int unsigned TIMEOUT_BASE_TICKS = 3600
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ts_sync,
    input  logic            ts_valid,
    input  logic [7:0]      ts_data,
    input  pcr_pkg::pcr_t   pcr_lo_data,
    output logic            pcr_cor_valid,
    output pcr_pkg::pcr_t   pcr_cor_data
);

    logic                  pcr_found;
    pcr_pkg::pid_t         pid;
    pcr_pkg::program_t     program_num;
    pcr_pkg::pcr_t         ori_pcr;
    pcr_pkg::pcr_t         lo_pcr;
    pcr_pkg::program_t     rd_addr;
    pcr_pkg::hist_entry_t  rd_entry;
    logic                  wr_en;
    pcr_pkg::program_t     wr_addr;
    pcr_pkg::hist_entry_t  wr_entry;

    ////////////////////
    // stream side
    ////////////////////

    pcr_field_parser i_parser (
        .clk         (clk),
        .rst         (rst),
        .ts_sync     (ts_sync),
        .ts_valid    (ts_valid),
        .ts_data     (ts_data),
        .pcr_lo_data (pcr_lo_data),
        .pcr_found   (pcr_found),
        .pid         (pid),
        .program_num (program_num),
        .ori_pcr     (ori_pcr),
        .lo_pcr      (lo_pcr)
    );

    ////////////////////
    // correction
    ////////////////////

    pcr_correct_pipe #(
        .TIMEOUT_BASE_TICKS (TIMEOUT_BASE_TICKS)
    ) i_pipe (
        .clk           (clk),
        .rst           (rst),
        .pcr_found     (pcr_found),
        .pid           (pid),
        .program_num   (program_num),
        .ori_pcr       (ori_pcr),
        .lo_pcr        (lo_pcr),
        .rd_entry      (rd_entry),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_entry      (wr_entry),
        .pcr_cor_valid (pcr_cor_valid),
        .pcr_cor_data  (pcr_cor_data)
    );

    // per-program history
    pcr_history_ram i_ram (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_entry (wr_entry),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry)
    );

endmodule

// File: logic/pcr_correct_pipe.sv
`timescale 1ns/1ps

module pcr_correct_pipe #(
    parameter int unsigned TIMEOUT_BASE_TICKS = 3600
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pcr_found,
    input  pcr_pkg::pid_t         pid,
    input  pcr_pkg::program_t     program_num,
    input  pcr_pkg::pcr_t         ori_pcr,
    input  pcr_pkg::pcr_t         lo_pcr,
    input  pcr_pkg::hist_entry_t  rd_entry,
    output pcr_pkg::program_t     rd_addr,
    output logic                  wr_en,
    output pcr_pkg::program_t     wr_addr,
    output pcr_pkg::hist_entry_t  wr_entry,
    output logic                  pcr_cor_valid,
    output pcr_pkg::pcr_t         pcr_cor_data
);

    localparam int EXT_W = $bits(pcr_pkg::pcr_ext_t);
    localparam int BASE_W = $bits(pcr_pkg::pcr_base_t);
    localparam logic [9:0] EXT_MOD = 10'(pcr_pkg::PCR_EXT_MODULUS);
    localparam pcr_pkg::pcr_base_t TIMEOUT = BASE_W'(TIMEOUT_BASE_TICKS);

    logic [5:0]           found_dly;
    pcr_pkg::pid_t        st_pid;
    pcr_pkg::pcr_t        st_lo;
    pcr_pkg::pcr_t        st_ori;
    logic                 lo_borrow;
    logic                 ori_borrow;
    logic [9:0]           lo_ext_wide;
    logic [9:0]           ext_sum;
    pcr_pkg::pcr_base_t   base_sum;
    pcr_pkg::pcr_base_t   diff_up;
    pcr_pkg::pcr_base_t   diff_down;
    logic                 reload;

    pcr_pkg::pcr_base_t   lo_base_iv_q;
    pcr_pkg::pcr_base_t   ori_base_iv_q;
    pcr_pkg::pcr_ext_t    lo_ext_iv_q;
    logic                 pid_match_q;
    pcr_pkg::pcr_t        prev_cor_q;
    pcr_pkg::pcr_t        cont_pcr_q;
    logic                 timeout_q;
    pcr_pkg::pcr_t        cor_buf_q;
    pcr_pkg::pcr_base_t   diff_q;

    // fields stay in place for the whole packet
    assign rd_addr = program_num;

    // stage enables, bit k is high in cycle k+1
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            found_dly <= '0;
        end
        else
        begin
            found_dly <= {found_dly[4:0], pcr_found};
        end
    end

    ////////////////////
    // intervals
    ////////////////////

    assign st_pid = rd_entry[pcr_pkg::HIST_PID_LSB +: $bits(pcr_pkg::pid_t)];
    assign st_lo = rd_entry[pcr_pkg::HIST_LO_LSB +: $bits(pcr_pkg::pcr_t)];
    assign st_ori = rd_entry[pcr_pkg::HIST_ORI_LSB +: $bits(pcr_pkg::pcr_t)];

    assign lo_borrow = lo_pcr[EXT_W-1:0] < st_lo[EXT_W-1:0];
    assign ori_borrow = ori_pcr[EXT_W-1:0] < st_ori[EXT_W-1:0];

    // extension difference modulo 300
    assign lo_ext_wide = lo_borrow
                       ? {1'b0, lo_pcr[EXT_W-1:0]} + EXT_MOD - {1'b0, st_lo[EXT_W-1:0]}
                       : {1'b0, lo_pcr[EXT_W-1:0]} - {1'b0, st_lo[EXT_W-1:0]};

    always_ff @(posedge clk)
    begin
        if (found_dly[1])
        begin
            lo_base_iv_q <= lo_pcr[EXT_W +: BASE_W] - st_lo[EXT_W +: BASE_W]
                            - BASE_W'(lo_borrow);
            ori_base_iv_q <= ori_pcr[EXT_W +: BASE_W] - st_ori[EXT_W +: BASE_W]
                             - BASE_W'(ori_borrow);
            lo_ext_iv_q <= lo_ext_wide[EXT_W-1:0];
            pid_match_q <= pid == st_pid;
            prev_cor_q <= rd_entry[pcr_pkg::HIST_COR_LSB +: $bits(pcr_pkg::pcr_t)];
        end
    end

    ////////////////////
    // correction
    ////////////////////

    assign ext_sum = {1'b0, prev_cor_q[EXT_W-1:0]} + {1'b0, lo_ext_iv_q};
    assign base_sum = prev_cor_q[EXT_W +: BASE_W] + lo_base_iv_q;

    always_ff @(posedge clk)
    begin
        if (found_dly[2])
        begin
            // extension wraps at 300 and carries into the base
            if (ext_sum >= EXT_MOD)
            begin
                cont_pcr_q <= {base_sum + BASE_W'(1), 9'(ext_sum - EXT_MOD)};
            end
            else
            begin
                cont_pcr_q <= {base_sum, ext_sum[EXT_W-1:0]};
            end
            timeout_q <= (lo_base_iv_q >= TIMEOUT) || (ori_base_iv_q >= TIMEOUT);
        end
    end

    ////////////////////
    // fallback and reload
    ////////////////////

    assign diff_up = ori_pcr[EXT_W +: BASE_W] - cor_buf_q[EXT_W +: BASE_W];
    assign diff_down = cor_buf_q[EXT_W +: BASE_W] - ori_pcr[EXT_W +: BASE_W];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cor_buf_q <= '0;
            diff_q <= '0;
        end
        else
        begin
            // continue only on the same pid within 40 ms
            if (found_dly[3])
            begin
                cor_buf_q <= (pid_match_q && !timeout_q) ? cont_pcr_q : ori_pcr;
            end
            // distance the short way round the 33-bit base
            if (found_dly[4])
            begin
                diff_q <= (diff_up > diff_down) ? diff_down : diff_up;
            end
        end
    end

    assign reload = |diff_q[BASE_W-1 -: pcr_pkg::RELOAD_MSB_COUNT];
    assign pcr_cor_data = reload ? ori_pcr : cor_buf_q;
    assign pcr_cor_valid = found_dly[5];

    ////////////////////
    // write-back
    ////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_en <= 1'b0;
        end
        else
        begin
            wr_en <= found_dly[5];
        end
    end

    always_ff @(posedge clk)
    begin
        if (found_dly[5])
        begin
            wr_addr <= program_num;
            wr_entry <= {pid, lo_pcr, ori_pcr, pcr_cor_data};
        end
    end

    ext_in_range: assert property (@(posedge clk) disable iff (rst)
        pcr_cor_valid |-> (pcr_cor_data[EXT_W-1:0] < 9'(pcr_pkg::PCR_EXT_MODULUS)))
        else $error("corrected PCR extension out of range");

    // packet spacing keeps at most one item in flight
    one_in_flight: assert property (@(posedge clk) disable iff (rst)
        pcr_found |-> (found_dly == '0) && !wr_en)
        else $error("pcr_found while the pipeline is busy");

endmodule

// File: logic/pcr_field_parser.sv
`timescale 1ns/1ps

module pcr_field_parser (
    input  logic                clk,
    input  logic                rst,
    input  logic                ts_sync,
    input  logic                ts_valid,
    input  logic [7:0]          ts_data,
    input  pcr_pkg::pcr_t       pcr_lo_data,
    output logic                pcr_found,
    output pcr_pkg::pid_t       pid,
    output pcr_pkg::program_t   program_num,
    output pcr_pkg::pcr_t       ori_pcr,
    output pcr_pkg::pcr_t       lo_pcr
);

    localparam logic [7:0] PKT_LEN = 8'(pcr_pkg::TS_PACKET_BYTES);

    logic [7:0] byte_cnt;
    logic [7:0] byte_idx;
    logic [1:0] adapt_ctrl;
    logic [7:0] adapt_len;
    logic       pcr_flag;
    logic       pcr_hit;

    // the sync byte is byte 0 whatever the counter holds
    assign byte_idx = ts_sync ? 8'd0 : byte_cnt;

    // last PCR byte of a packet that carries a PCR
    assign pcr_hit = ts_valid && (byte_idx == 8'd11) && adapt_ctrl[1]
                     && (adapt_len != 8'd0) && pcr_flag;

    ////////////////////
    // byte position
    ////////////////////

    // parked at the packet length until the next sync
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            byte_cnt <= PKT_LEN;
        end
        else if (ts_valid && (byte_idx < PKT_LEN))
        begin
            byte_cnt <= byte_idx + 8'd1;
        end
    end

    ////////////////////
    // header fields
    ////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pid         <= '0;
            adapt_ctrl  <= 2'b00;
            adapt_len   <= 8'h00;
            pcr_flag    <= 1'b0;
            program_num <= '0;
            pcr_found   <= 1'b0;
        end
        else
        begin
            pcr_found <= pcr_hit;
            if (ts_valid)
            begin
                case (byte_idx)
                    8'd1: pid[12:8] <= ts_data[4:0];
                    8'd2: pid[7:0] <= ts_data;
                    8'd3: adapt_ctrl <= ts_data[5:4];
                    8'd4: adapt_len <= ts_data;
                    8'd5: pcr_flag <= ts_data[4];
                    // program number rides in the reserved PCR bits
                    8'd10: program_num <= ts_data[4:1];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // PCR values
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (ts_valid)
        begin
            case (byte_idx)
                8'd6: ori_pcr[41:34] <= ts_data;
                8'd7: ori_pcr[33:26] <= ts_data;
                8'd8: ori_pcr[25:18] <= ts_data;
                8'd9: ori_pcr[17:10] <= ts_data;
                8'd10:
                begin
                    ori_pcr[9] <= ts_data[7];
                    ori_pcr[8] <= ts_data[0];
                end
                8'd11: ori_pcr[7:0] <= ts_data;
                default: ;
            endcase
        end
        // local time at the PCR arrival
        if (pcr_hit)
        begin
            lo_pcr <= pcr_lo_data;
        end
    end

    sync_with_valid: assert property (@(posedge clk) disable iff (rst)
        ts_sync |-> ts_valid)
        else $error("ts_sync high while ts_valid low");

endmodule

// File: logic/pcr_history_ram.sv
`timescale 1ns/1ps

module pcr_history_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  pcr_pkg::program_t     wr_addr,
    input  pcr_pkg::hist_entry_t  wr_entry,
    input  pcr_pkg::program_t     rd_addr,
    output pcr_pkg::hist_entry_t  rd_entry
);

    localparam int RAM_DEPTH = 2 ** $bits(pcr_pkg::program_t);

    pcr_pkg::hist_entry_t mem [RAM_DEPTH];
    pcr_pkg::program_t    rd_addr_q;

    // one entry per program, all zero out of reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < RAM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
            rd_addr_q <= '0;
        end
        else
        begin
            rd_addr_q <= rd_addr;
            if (wr_en)
            begin
                mem[wr_addr] <= wr_entry;
            end
        end
    end

    // second read register, old word on a same-edge write
    always_ff @(posedge clk)
    begin
        rd_entry <= mem[rd_addr_q];
    end

    // a new read never shows up in a write cycle
    no_read_on_write: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> $stable(rd_addr))
        else $error("read address changed during a table write");

endmodule

// File: logic/pcr_pkg.sv
package pcr_pkg;

    ////////////////////
    // field types
    ////////////////////

    typedef logic [12:0] pid_t;

    // also the history table address
    typedef logic [3:0] program_t;

    // 90 kHz part of a PCR
    typedef logic [32:0] pcr_base_t;

    // 27 MHz remainder, always 0..299
    typedef logic [8:0] pcr_ext_t;

    // base in the upper bits, extension in the lower nine
    typedef logic [41:0] pcr_t;

    ////////////////////
    // constants
    ////////////////////

    localparam int PCR_EXT_MODULUS = 300;
    localparam int TS_PACKET_BYTES = 188;

    // any of the top four base-difference bits set means 2^29 ticks or more
    localparam int RELOAD_MSB_COUNT = 4;

    ////////////////////
    // history word
    ////////////////////

    // pid on top, then local, original and corrected PCR
    localparam int HIST_COR_LSB = 0;
    localparam int HIST_ORI_LSB = HIST_COR_LSB + $bits(pcr_t);
    localparam int HIST_LO_LSB = HIST_ORI_LSB + $bits(pcr_t);
    localparam int HIST_PID_LSB = HIST_LO_LSB + $bits(pcr_t);
    localparam int HIST_ENTRY_BITS = HIST_PID_LSB + $bits(pid_t);

    typedef logic [HIST_ENTRY_BITS-1:0] hist_entry_t;

endpackage

// File: src.f
logic/pcr_pkg.sv
logic/pcr_field_parser.sv
logic/pcr_history_ram.sv
logic/pcr_correct_pipe.sv
logic/pcr_accuracy_adapt.sv
testbench/tb_pcr_accuracy_adapt.sv

// File: testbench/pcr_cases.txt
# prog pid ctrl len flag ori_base ori_ext lo_base lo_ext exp_base exp_ext, all decimal
# exp_base -1 means no corrected PCR is expected for that packet
1 100 3 7 1 1000000 50 5000 10 1000000 50
1 100 3 7 1 1001000 60 6000 110 1001000 150
1 100 3 7 1 1002000 0 7000 290 1002001 30
1 100 3 7 1 1003000 100 8000 40 1003000 80
2 200 3 7 1 500000 0 8100 0 500000 0
1 100 3 7 1 1004000 5 11700 40 1004000 5
2 200 3 7 1 501000 7 9100 20 501000 20
1 100 3 7 0 9999 0 12000 0 -1 0
1 100 1 7 1 9999 0 12000 0 -1 0
1 100 3 0 1 9999 0 12000 0 -1 0
1 100 3 7 1 1005000 50 12700 140 1005000 105
2 201 3 7 1 502000 7 10100 20 502000 7
1 100 3 7 1 1010000 50 13700 140 1010000 50
2 201 3 7 1 502900 7 11000 120 502900 107

// File: testbench/tb_pcr_accuracy_adapt.sv
`timescale 1ns/1ps

module tb_pcr_accuracy_adapt;

    localparam int CLK_PERIOD = 8;
    localparam int CYCLES_PER_CASE = 400;
    localparam int OUT_LATENCY = 7;

    logic          clk;
    logic          rst;
    logic          ts_sync;
    logic          ts_valid;
    logic [7:0]    ts_data;
    pcr_pkg::pcr_t pcr_lo_data;
    logic          pcr_cor_valid;
    pcr_pkg::pcr_t pcr_cor_data;

    // one entry per line of the case file
    int      c_prog[$];
    int      c_pid[$];
    int      c_ctrl[$];
    int      c_len[$];
    int      c_flag[$];
    longint  c_ori_base[$];
    longint  c_ori_ext[$];
    longint  c_lo_base[$];
    longint  c_lo_ext[$];
    longint  c_exp_base[$];
    longint  c_exp_ext[$];
    int      n_cases;

    pcr_pkg::pcr_t  exp_q[$];
    logic           pcr_mark;
    logic [6:0]     mark_sh;
    integer         seed;

    pcr_accuracy_adapt i_dut (
        .clk           (clk),
        .rst           (rst),
        .ts_sync       (ts_sync),
        .ts_valid      (ts_valid),
        .ts_data       (ts_data),
        .pcr_lo_data   (pcr_lo_data),
        .pcr_cor_valid (pcr_cor_valid),
        .pcr_cor_data  (pcr_cor_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    ////////////////////
    // reporting
    ////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_pcr(input pcr_pkg::pcr_t actual, input pcr_pkg::pcr_t expected);
        if (actual !== expected)
        begin
            fail_run($sformatf("FAIL pcr_cor_data got %h expected %h", actual, expected));
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            if (expected)
            begin
                fail_run("corrected PCR strobe missing seven cycles after the PCR byte");
            end
            else
            begin
                fail_run("corrected PCR strobe seen where no PCR was sent");
            end
        end
    endtask

    ////////////////////
    // case file
    ////////////////////

    task automatic read_cases();
        int     fd;
        int     got;
        string  line;
        int     prog;
        int     pid;
        int     ctrl;
        int     len;
        int     flag;
        longint v[6];
        fd = $fopen("testbench/pcr_cases.txt", "r");
        if (fd == 0)
        begin
            fail_run("could not open testbench/pcr_cases.txt");
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            got = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", prog, pid, ctrl,
                          len, flag, v[0], v[1], v[2], v[3], v[4], v[5]);
            if (got != 11)
            begin
                fail_run($sformatf("malformed case line: %s", line));
            end
            c_prog.push_back(prog);
            c_pid.push_back(pid);
            c_ctrl.push_back(ctrl);
            c_len.push_back(len);
            c_flag.push_back(flag);
            c_ori_base.push_back(v[0]);
            c_ori_ext.push_back(v[1]);
            c_lo_base.push_back(v[2]);
            c_lo_ext.push_back(v[3]);
            c_exp_base.push_back(v[4]);
            c_exp_ext.push_back(v[5]);
        end
        $fclose(fd);
    endtask

    ////////////////////
    // stream driver
    ////////////////////

    // a valid byte, sometimes after an idle cycle
    task automatic send_byte(input logic [7:0] data, input logic sync, input logic mark);
        while (($random(seed) & 15) == 0)
        begin
            @(posedge clk);
            ts_valid <= 1'b0;
            ts_sync  <= 1'b0;
            pcr_mark <= 1'b0;
        end
        @(posedge clk);
        ts_valid <= 1'b1;
        ts_sync  <= sync;
        ts_data  <= data;
        pcr_mark <= mark;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            ts_valid <= 1'b0;
            ts_sync  <= 1'b0;
            pcr_mark <= 1'b0;
        end
    endtask

    task automatic send_packet(input int idx);
        pcr_pkg::pcr_t ori;
        logic          has_pcr;
        logic [3:0]    prog;
        logic [12:0]   pid;
        ori = {33'(c_ori_base[idx]), 9'(c_ori_ext[idx])};
        prog = 4'(c_prog[idx]);
        pid = 13'(c_pid[idx]);
        has_pcr = (c_exp_base[idx] >= 0);
        if (has_pcr)
        begin
            exp_q.push_back({33'(c_exp_base[idx]), 9'(c_exp_ext[idx])});
        end
        pcr_lo_data <= {33'(c_lo_base[idx]), 9'(c_lo_ext[idx])};
        send_byte(8'h47, 1'b1, 1'b0);
        send_byte({3'b000, pid[12:8]}, 1'b0, 1'b0);
        send_byte(pid[7:0], 1'b0, 1'b0);
        send_byte({2'b00, 2'(c_ctrl[idx]), 4'(idx)}, 1'b0, 1'b0);
        send_byte(8'(c_len[idx]), 1'b0, 1'b0);
        send_byte({3'b000, 1'(c_flag[idx]), 4'b0000}, 1'b0, 1'b0);
        send_byte(ori[41:34], 1'b0, 1'b0);
        send_byte(ori[33:26], 1'b0, 1'b0);
        send_byte(ori[25:18], 1'b0, 1'b0);
        send_byte(ori[17:10], 1'b0, 1'b0);
        // base lsb, reserved bits holding the program, extension msb
        send_byte({ori[9], 2'b11, prog, ori[8]}, 1'b0, 1'b0);
        send_byte(ori[7:0], 1'b0, has_pcr);
        for (int b = 12; b < pcr_pkg::TS_PACKET_BYTES; b++)
        begin
            send_byte(8'($random(seed)), 1'b0, 1'b0);
        end
        idle_cycles(4);
    endtask

    ////////////////////
    // output monitor
    ////////////////////

    always @(posedge clk)
    begin
        if (rst)
        begin
            mark_sh = '0;
        end
        else
        begin
            check_valid(pcr_cor_valid, mark_sh[OUT_LATENCY-1]);
            if (pcr_cor_valid)
            begin
                check_pcr(pcr_cor_data, exp_q.pop_front());
            end
            mark_sh = {mark_sh[5:0], pcr_mark};
        end
    end

    // watchdog scaled to the number of cases
    initial
    begin
        wait (n_cases > 0);
        repeat (CYCLES_PER_CASE * n_cases + 50)
        begin
            @(posedge clk);
        end
        fail_run("timeout, the run did not finish in time");
    end

    initial
    begin
        seed = 32'hb067;
        n_cases = 0;
        rst = 1'b1;
        ts_sync = 1'b0;
        ts_valid = 1'b0;
        ts_data = 8'h00;
        pcr_lo_data = '0;
        pcr_mark = 1'b0;
        read_cases();
        n_cases = c_prog.size();
        repeat (4)
        begin
            @(posedge clk);
        end
        rst <= 1'b0;
        idle_cycles(3);
        for (int i = 0; i < n_cases; i++)
        begin
            send_packet(i);
        end
        // let the last result drain
        idle_cycles(20);
        if (exp_q.size() != 0)
        begin
            fail_run($sformatf("%0d expected results never appeared", exp_q.size()));
        end
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
